/* zx_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Shared constants and types of the I/O subsystem
////////////////////////////////////////////////////////////////////////////

package zx_pkg;

   // AXI4-Lite host bus
   localparam int AXI_ADDR_W = 4;    // 16 bytes of register space
   localparam int AXI_DATA_W = 32;

   typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
   typedef logic [AXI_DATA_W-1:0] axi_data_t;

   typedef logic [7:0] spi_byte_t;   // One SPI transfer

   // Register map, byte offsets
   localparam axi_addr_t REG_CTRL   = 4'h0;
   localparam axi_addr_t REG_TXDATA = 4'h4;
   localparam axi_addr_t REG_RXDATA = 4'h8;
   localparam axi_addr_t REG_STATUS = 4'hC;

   // CTRL bits
   localparam int CTRL_FLASH_SEL = 0;   // Boot flash chip select
   localparam int CTRL_SD_SEL    = 1;   // SD card chip select

   // LED stretch counter, top bit set means idle
   localparam int LED_HOLD_BITS = 20;

   // AXI responses
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   // Byte engine states
   typedef enum logic [1:0] {
      IDLE,    // Waiting for start
      SHIFT,   // Clocking the 8 bits
      DONE     // Latch received byte
   } spi_state_t;

endpackage

`default_nettype wire

/* clock_enables.sv */
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Machine timing base, enables at sysclk/2, /4 and /8
////////////////////////////////////////////////////////////////////////////

module clock_enables (
   input wire sysclk,
   input wire rst,
   output logic ce14,    // 14 MHz enable
   output logic ce7,     // 7 MHz enable
   output logic ce35     // 3.5 MHz enable
);

   logic [2:0] clkdiv;   // Free running divider

   always_ff @(posedge sysclk) begin
      if (rst) begin
         clkdiv <= 3'd0;
      end else begin
         clkdiv <= clkdiv + 3'd1;
      end
   end

   // Each enable fires in the cycle before its divider bit rises
   assign ce14 = ~clkdiv[0];
   assign ce7  = clkdiv[0] & ~clkdiv[1];
   assign ce35 = clkdiv[0] & clkdiv[1] & ~clkdiv[2];   // Carry into bit 2

endmodule

`default_nettype wire

/* spi_byte_engine.sv */
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Mode 0 SPI byte shifter, MSB first, SCK toggled on each ce14
////////////////////////////////////////////////////////////////////////////

module spi_byte_engine (
   input wire sysclk,
   input wire rst,
   input wire ce14,                     // Paces SCK, period 4 sysclk
   input wire start,                    // One cycle, only honored in IDLE
   input wire zx_pkg::spi_byte_t tx_byte,
   input wire flash_sel,                // Picks which miso to sample
   input wire flash_miso,
   input wire sd_miso,
   output logic sck,
   output logic mosi,
   output logic busy,
   output zx_pkg::spi_byte_t rx_byte    // Valid once busy falls
);

   zx_pkg::spi_state_t state;
   zx_pkg::spi_byte_t tx_sr;            // Outgoing bits, MSB on the wire
   zx_pkg::spi_byte_t rx_sr;            // Incoming bits
   logic [2:0] bit_cnt;                 // Completed SCK periods
   logic miso;

   // Only the selected device may talk back
   assign miso = flash_sel ? flash_miso : sd_miso;

   assign mosi = (state == zx_pkg::SHIFT) & tx_sr[7];   // Line low when idle
   assign busy = (state != zx_pkg::IDLE);

   // Control path
   always_ff @(posedge sysclk) begin
      if (rst) begin
         state   <= zx_pkg::IDLE;
         sck     <= 1'b0;
         bit_cnt <= 3'd0;
      end else begin
         case (state)
            zx_pkg::IDLE: begin
               bit_cnt <= 3'd0;
               if (start) begin
                  state <= zx_pkg::SHIFT;   // First edge waits for ce14
               end
            end
            zx_pkg::SHIFT: begin
               if (ce14) begin
                  sck <= ~sck;
                  if (sck) begin            // Falling edge ends a bit
                     bit_cnt <= bit_cnt + 3'd1;
                     if (bit_cnt == 3'd7) begin
                        state <= zx_pkg::DONE;
                     end
                  end
               end
            end
            zx_pkg::DONE: begin
               state <= zx_pkg::IDLE;
            end
            default: begin
               state <= zx_pkg::IDLE;
               sck   <= 1'b0;
            end
         endcase
      end
   end

   // Data path
   always_ff @(posedge sysclk) begin
      if (state == zx_pkg::IDLE && start) begin
         tx_sr <= tx_byte;
      end else if (state == zx_pkg::SHIFT && ce14) begin
         if (!sck) begin
            rx_sr <= {rx_sr[6:0], miso};     // Sample on rising SCK
         end else begin
            tx_sr <= {tx_sr[6:0], 1'b0};     // Next bit while SCK low
         end
      end

      if (state == zx_pkg::DONE) begin
         rx_byte <= rx_sr;
      end
   end

endmodule

`default_nettype wire

/* spi_regs_axil.sv */
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// AXI4-Lite register slave for the SPI engine
////////////////////////////////////////////////////////////////////////////

module spi_regs_axil (
   input wire sysclk,
   input wire rst,
   // Write address and data
   input wire zx_pkg::axi_addr_t awaddr,
   input wire awvalid,
   output logic awready,
   input wire zx_pkg::axi_data_t wdata,
   input wire [zx_pkg::AXI_DATA_W/8-1:0] wstrb,
   input wire wvalid,
   output logic wready,
   // Write response
   output logic bvalid,
   output logic [1:0] bresp,
   input wire bready,
   // Read address and data
   input wire zx_pkg::axi_addr_t araddr,
   input wire arvalid,
   output logic arready,
   output logic rvalid,
   output zx_pkg::axi_data_t rdata,
   output logic [1:0] rresp,
   input wire rready,
   // Byte engine side
   output logic start,
   output zx_pkg::spi_byte_t tx_byte,
   input wire busy,
   input wire zx_pkg::spi_byte_t rx_byte,
   output logic flash_sel,
   output logic sd_sel
);

   logic [1:0] ctrl;       // Chip select bits
   logic wr_accept;
   logic rd_accept;
   logic tx_write;         // Accepted write aimed at TXDATA

   // Address and data taken together, blocked while a response waits
   assign wr_accept = awvalid & wvalid & ~bvalid;
   assign awready   = wr_accept;
   assign wready    = wr_accept;
   assign rd_accept = arvalid & ~rvalid;
   assign arready   = rd_accept;

   assign tx_write = wr_accept && (awaddr == zx_pkg::REG_TXDATA);

   assign flash_sel = ctrl[zx_pkg::CTRL_FLASH_SEL];
   assign sd_sel    = ctrl[zx_pkg::CTRL_SD_SEL];

   ////////////////////////////////////////////////////////////////////////////
   // Write channel
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge sysclk) begin
      if (rst) begin
         ctrl   <= 2'b00;   // Both devices deselected
         bvalid <= 1'b0;
         start  <= 1'b0;
      end else begin
         start <= tx_write & ~busy & wstrb[0];   // Single cycle kick
         if (bvalid && bready) begin
            bvalid <= 1'b0;
         end
         if (wr_accept) begin
            bvalid <= 1'b1;
            if (awaddr == zx_pkg::REG_CTRL && wstrb[0]) begin
               ctrl <= wdata[1:0];
            end
         end
      end
   end

   // Response code and transmit byte
   always_ff @(posedge sysclk) begin
      if (wr_accept) begin
         case (awaddr)
            zx_pkg::REG_CTRL:   bresp <= zx_pkg::RESP_OKAY;
            zx_pkg::REG_TXDATA: bresp <= busy ? zx_pkg::RESP_SLVERR : zx_pkg::RESP_OKAY;
            default:            bresp <= zx_pkg::RESP_SLVERR;   // RX, STATUS, holes
         endcase
      end
      if (tx_write && !busy && wstrb[0]) begin
         tx_byte <= wdata[7:0];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read channel
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge sysclk) begin
      if (rst) begin
         rvalid <= 1'b0;
      end else if (rd_accept) begin
         rvalid <= 1'b1;
      end else if (rready) begin
         rvalid <= 1'b0;    // Held until the host takes it
      end
   end

   always_ff @(posedge sysclk) begin
      if (rd_accept) begin
         rdata <= '0;
         rresp <= zx_pkg::RESP_OKAY;
         case (araddr)
            zx_pkg::REG_CTRL:   rdata[1:0] <= ctrl;
            zx_pkg::REG_TXDATA: rdata[7:0] <= tx_byte;
            zx_pkg::REG_RXDATA: rdata[7:0] <= rx_byte;
            zx_pkg::REG_STATUS: rdata[0]   <= busy;
            default:            rresp      <= zx_pkg::RESP_SLVERR;   // Data stays 0
         endcase
      end
   end

endmodule

`default_nettype wire

/* activity_led.sv */
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Monostable for the SPI activity LED
////////////////////////////////////////////////////////////////////////////

module activity_led (
   input wire sysclk,
   input wire rst,
   input wire flash_cs_n,
   input wire sd_cs_n,
   output logic testled
);

   logic [zx_pkg::LED_HOLD_BITS-1:0] hold_cnt;   // Top bit set means expired

   always_ff @(posedge sysclk) begin
      if (rst) begin
         hold_cnt <= '1;                            // Start dark
      end else if (!flash_cs_n || !sd_cs_n) begin
         hold_cnt <= '0;                            // Retrigger on any select
      end else if (!hold_cnt[zx_pkg::LED_HOLD_BITS-1]) begin
         hold_cnt <= hold_cnt + 1'b1;
      end
   end

   assign testled = ~hold_cnt[zx_pkg::LED_HOLD_BITS-1];

endmodule

`default_nettype wire

/* zxuno_io_top.sv */
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Board I/O top, host bus to the shared SPI pins and activity LED
////////////////////////////////////////////////////////////////////////////

module zxuno_io_top (
   input wire sysclk,
   input wire rst,
   // Host bus
   input wire zx_pkg::axi_addr_t awaddr,
   input wire awvalid,
   output logic awready,
   input wire zx_pkg::axi_data_t wdata,
   input wire [zx_pkg::AXI_DATA_W/8-1:0] wstrb,
   input wire wvalid,
   output logic wready,
   output logic bvalid,
   output logic [1:0] bresp,
   input wire bready,
   input wire zx_pkg::axi_addr_t araddr,
   input wire arvalid,
   output logic arready,
   output logic rvalid,
   output zx_pkg::axi_data_t rdata,
   output logic [1:0] rresp,
   input wire rready,
   // Boot flash
   output logic flash_cs_n,
   output logic flash_clk,
   output logic flash_mosi,
   input wire flash_miso,
   // SD card
   output logic sd_cs_n,
   output logic sd_clk,
   output logic sd_mosi,
   input wire sd_miso,
   output logic testled   // SPI activity
);

   logic ce14;
   logic start, busy;
   zx_pkg::spi_byte_t tx_byte, rx_byte;
   logic flash_sel, sd_sel;
   logic sck, mosi;

   clock_enables clock_enables_inst (
      .sysclk(sysclk), .rst(rst),
      .ce14(ce14),
      .ce7(),       // Reserved for the machine core
      .ce35()
   );

   spi_regs_axil spi_regs_axil_inst (
      .sysclk(sysclk), .rst(rst),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bvalid(bvalid), .bresp(bresp), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
      .start(start), .tx_byte(tx_byte), .busy(busy), .rx_byte(rx_byte),
      .flash_sel(flash_sel), .sd_sel(sd_sel)
   );

   spi_byte_engine spi_byte_engine_inst (
      .sysclk(sysclk), .rst(rst), .ce14(ce14),
      .start(start), .tx_byte(tx_byte), .flash_sel(flash_sel),
      .flash_miso(flash_miso), .sd_miso(sd_miso),
      .sck(sck), .mosi(mosi), .busy(busy), .rx_byte(rx_byte)
   );

   // Chip selects are active low
   assign flash_cs_n = ~flash_sel;
   assign sd_cs_n    = ~sd_sel;

   // Both devices share clock and data
   assign flash_clk  = sck;
   assign sd_clk     = sck;
   assign flash_mosi = mosi;
   assign sd_mosi    = mosi;

   activity_led activity_led_inst (
      .sysclk(sysclk), .rst(rst),
      .flash_cs_n(flash_cs_n), .sd_cs_n(sd_cs_n),
      .testled(testled)
   );

endmodule

`default_nettype wire

/* tb_zxuno_io.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_zxuno_io;

   localparam int NUM_XFERS    = 43;   // 1 register test + 2 x 20 + 2 busy case
   localparam int LED_HOLD     = 2 ** (zx_pkg::LED_HOLD_BITS - 1);
   localparam int POLL_LIMIT   = 64;   // STATUS reads per transfer
   localparam int WATCHDOG_CYC = NUM_XFERS * 64 + LED_HOLD + 20000;

   logic sysclk, rst;
   zx_pkg::axi_addr_t awaddr, araddr;
   zx_pkg::axi_data_t wdata, rdata;
   logic [3:0] wstrb;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   logic [1:0] bresp, rresp;
   logic flash_cs_n, flash_clk, flash_mosi, flash_miso;
   logic sd_cs_n, sd_clk, sd_mosi, sd_miso;
   logic testled;

   int checks, mismatches, other_errors;
   int flash_sck_edges, sd_sck_edges;    // Rising SCK edges at each device
   logic flash_phase, sd_phase;          // Chip select must hold low
   zx_pkg::spi_byte_t exp_q[$], act_q[$];
   string name_q[$];

   zxuno_io_top zxuno_io_top_inst (
      .sysclk(sysclk), .rst(rst),
      .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
      .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
      .bvalid(bvalid), .bresp(bresp), .bready(bready),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
      .flash_cs_n(flash_cs_n), .flash_clk(flash_clk), .flash_mosi(flash_mosi),
      .flash_miso(flash_miso),
      .sd_cs_n(sd_cs_n), .sd_clk(sd_clk), .sd_mosi(sd_mosi), .sd_miso(sd_miso),
      .testled(testled)
   );

   // Device models
   assign flash_miso = flash_mosi;   // Loopback flash
   assign sd_miso    = ~sd_mosi;     // Inverting card

   // SCK activity as the devices see it
   always @(posedge flash_clk) flash_sck_edges++;
   always @(posedge sd_clk) sd_sck_edges++;

   initial sysclk = 1'b0;
   always #4 sysclk = ~sysclk;       // 8 ns period

   // Received byte predicted from CTRL and the sent byte
   function automatic zx_pkg::spi_byte_t expected_rx(input logic [1:0] ctrl_val,
                                                     input zx_pkg::spi_byte_t tx);
      return ctrl_val[zx_pkg::CTRL_FLASH_SEL] ? tx : ~tx;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act == exp) else begin
         $display("Mismatch %s: expected %08h, actual %08h", name, exp, act);
         mismatches++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // AXI4-Lite host, called 1 ns after a rising edge
   ////////////////////////////////////////////////////////////////////////////

   task automatic write_reg(input zx_pkg::axi_addr_t addr, input zx_pkg::axi_data_t data,
                            output logic [1:0] resp);
      logic accepted;
      accepted = 1'b0;
      awaddr   = addr;
      wdata    = data;
      wstrb    = 4'hF;
      awvalid  = 1'b1;
      wvalid   = 1'b1;
      while (!accepted) begin
         @(negedge sysclk);
         accepted = awready & wready;   // Value seen by the next edge
         @(posedge sysclk);
         #1;
      end
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      @(negedge sysclk);
      while (!bvalid) @(negedge sysclk);
      resp = bresp;
      @(posedge sysclk);
      #1;
      bready = 1'b0;
   endtask

   task automatic read_reg(input zx_pkg::axi_addr_t addr, output zx_pkg::axi_data_t data,
                           output logic [1:0] resp);
      logic accepted;
      accepted = 1'b0;
      araddr   = addr;
      arvalid  = 1'b1;
      while (!accepted) begin
         @(negedge sysclk);
         accepted = arready;
         @(posedge sysclk);
         #1;
      end
      arvalid = 1'b0;
      rready  = 1'b1;
      @(negedge sysclk);
      while (!rvalid) @(negedge sysclk);
      data = rdata;
      resp = rresp;
      @(posedge sysclk);
      #1;
      rready = 1'b0;
   endtask

   // Poll STATUS until the busy bit clears
   task automatic wait_not_busy(input string name);
      zx_pkg::axi_data_t status;
      logic [1:0] resp;
      int polls;
      polls  = 0;
      status = 32'h1;
      while (status[0] && polls < POLL_LIMIT) begin
         read_reg(zx_pkg::REG_STATUS, status, resp);
         polls++;
      end
      assert (!status[0]) else begin
         $display("%s: SPI engine still busy after %0d status reads", name, polls);
         other_errors++;
      end
   endtask

   task automatic transfer_byte(input string name, input logic [1:0] ctrl_val,
                                input zx_pkg::axi_data_t word);
      logic [1:0] resp;
      zx_pkg::axi_data_t rd;
      int flash_start, sd_start;
      flash_start = flash_sck_edges;
      sd_start    = sd_sck_edges;
      exp_q.push_back(expected_rx(ctrl_val, word[7:0]));
      name_q.push_back(name);
      write_reg(zx_pkg::REG_TXDATA, word, resp);   // Upper bits ignored
      check_value({name, " TXDATA bresp"}, 32'(zx_pkg::RESP_OKAY), 32'(resp));
      wait_not_busy(name);
      // One byte is 8 SCK periods on both device clocks
      check_value({name, " flash_clk edges"}, 32'd8, 32'(flash_sck_edges - flash_start));
      check_value({name, " sd_clk edges"}, 32'd8, 32'(sd_sck_edges - sd_start));
      read_reg(zx_pkg::REG_RXDATA, rd, resp);
      act_q.push_back(rd[7:0]);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Checkers
   ////////////////////////////////////////////////////////////////////////////

   always @(negedge sysclk) begin : compare_rx
      zx_pkg::spi_byte_t exp_b, act_b;
      string name;
      if (exp_q.size() != 0 && act_q.size() != 0) begin
         exp_b = exp_q.pop_front();
         act_b = act_q.pop_front();
         name  = name_q.pop_front();
         checks++;
         assert (act_b == exp_b) else begin
            $display("Mismatch %s: expected %02h, actual %02h", name, exp_b, act_b);
            mismatches++;
         end
      end
   end

   always @(negedge sysclk) begin
      if (flash_phase) begin
         assert (!flash_cs_n && testled) else begin
            $display("Flash chip select or activity LED went inactive during a transfer");
            other_errors++;
         end
      end
      if (sd_phase) begin
         assert (!sd_cs_n && testled) else begin
            $display("SD chip select or activity LED went inactive during a transfer");
            other_errors++;
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYC) @(posedge sysclk);
      $display("Timeout after %0d cycles, the test sequence did not finish", WATCHDOG_CYC);
      $display("Checks: %0d, mismatches: %0d, other errors: %0d",
               checks, mismatches, other_errors);
      $display("*** FAILED ***");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial begin : stimulus
      zx_pkg::axi_data_t rd, word;
      logic [1:0] resp;
      int i;
      checks = 0;
      mismatches = 0;
      other_errors = 0;
      flash_sck_edges = 0;
      sd_sck_edges = 0;
      flash_phase = 1'b0;
      sd_phase = 1'b0;
      rst = 1'b1;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = 4'h0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      void'($urandom(70473));
      repeat (10) @(posedge sysclk);
      #1;
      rst = 1'b0;

      // Reset state
      @(negedge sysclk);
      check_value("reset flash_cs_n", 32'd1, 32'(flash_cs_n));
      check_value("reset sd_cs_n", 32'd1, 32'(sd_cs_n));
      check_value("reset testled", 32'd0, 32'(testled));
      check_value("reset flash_clk", 32'd0, 32'(flash_clk));
      check_value("reset sd_clk", 32'd0, 32'(sd_clk));
      @(posedge sysclk);
      #1;
      read_reg(zx_pkg::REG_STATUS, rd, resp);
      check_value("reset STATUS", 32'd0, rd);
      check_value("reset STATUS rresp", 32'(zx_pkg::RESP_OKAY), 32'(resp));
      read_reg(zx_pkg::REG_CTRL, rd, resp);
      check_value("reset CTRL", 32'd0, rd);

      // Register access rules
      write_reg(zx_pkg::REG_CTRL, 32'hFFFF_FFF7, resp);
      check_value("CTRL bresp", 32'(zx_pkg::RESP_OKAY), 32'(resp));
      read_reg(zx_pkg::REG_CTRL, rd, resp);
      check_value("CTRL readback", 32'hFFFF_FFF7 & 32'h3, rd);
      write_reg(zx_pkg::REG_CTRL, 32'h0, resp);
      write_reg(zx_pkg::REG_TXDATA, 32'hC0DE_5A3C, resp);
      read_reg(zx_pkg::REG_TXDATA, rd, resp);
      check_value("TXDATA readback", 32'h3C, rd);
      wait_not_busy("TXDATA readback");
      write_reg(zx_pkg::REG_RXDATA, 32'h55, resp);
      check_value("RXDATA write bresp", 32'(zx_pkg::RESP_SLVERR), 32'(resp));
      write_reg(zx_pkg::REG_STATUS, 32'h1, resp);
      check_value("STATUS write bresp", 32'(zx_pkg::RESP_SLVERR), 32'(resp));
      write_reg(4'hD, 32'h1, resp);
      check_value("offset 0xD bresp", 32'(zx_pkg::RESP_SLVERR), 32'(resp));
      write_reg(4'hF, 32'h1, resp);
      check_value("offset 0xF bresp", 32'(zx_pkg::RESP_SLVERR), 32'(resp));
      read_reg(4'hE, rd, resp);
      check_value("offset 0xE rresp", 32'(zx_pkg::RESP_SLVERR), 32'(resp));
      check_value("offset 0xE rdata", 32'd0, rd);

      // Flash transfers, then a write during busy
      write_reg(zx_pkg::REG_CTRL, 32'h1, resp);
      flash_phase = 1'b1;
      for (i = 0; i < 20; i++) begin
         transfer_byte($sformatf("flash byte %0d", i), 2'b01, $urandom);
      end
      word = $urandom;
      exp_q.push_back(expected_rx(2'b01, word[7:0]));
      name_q.push_back("busy rejection");
      write_reg(zx_pkg::REG_TXDATA, word, resp);
      check_value("busy first bresp", 32'(zx_pkg::RESP_OKAY), 32'(resp));
      write_reg(zx_pkg::REG_TXDATA, ~word, resp);   // Engine still shifting
      check_value("busy second bresp", 32'(zx_pkg::RESP_SLVERR), 32'(resp));
      wait_not_busy("busy rejection");
      read_reg(zx_pkg::REG_RXDATA, rd, resp);
      act_q.push_back(rd[7:0]);
      flash_phase = 1'b0;

      // SD transfers
      write_reg(zx_pkg::REG_CTRL, 32'h2, resp);
      sd_phase = 1'b1;
      for (i = 0; i < 20; i++) begin
         transfer_byte($sformatf("sd byte %0d", i), 2'b10, $urandom);
      end
      sd_phase = 1'b0;

      // LED hold after the last select
      write_reg(zx_pkg::REG_CTRL, 32'h0, resp);
      repeat (1000) @(posedge sysclk);
      @(negedge sysclk);
      check_value("testled during hold", 32'd1, 32'(testled));
      repeat (LED_HOLD + 64) @(posedge sysclk);
      @(negedge sysclk);
      check_value("testled after hold", 32'd0, 32'(testled));

      $display("Checks: %0d, mismatches: %0d, other errors: %0d",
               checks, mismatches, other_errors);
      if (mismatches + other_errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
zx_pkg.sv
clock_enables.sv
spi_byte_engine.sv
spi_regs_axil.sv
activity_led.sv
zxuno_io_top.sv
tb_zxuno_io.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
   --top-module tb_zxuno_io -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output="$(./obj_dir/Vtb_zxuno_io)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
   exit 0
fi
exit 1
